// File: bench/udp_rx_noc_checker.sv
module udp_rx_noc_checker (
    input logic               clk,
    input logic               rst,
    input logic               out_val,
    input udp_rx_pkg::rx_flit out_flit,
    input udp_rx_pkg::rx_meta out_meta,
    input logic               drop
);

    timeunit 1ns;
    timeprecision 100ps;

    // only the last flit of a packet carries pad bytes
    pad_only_on_last: assert property (@(posedge clk) disable iff (rst)
        out_val && !out_flit.last |-> out_flit.padbytes == '0)
        else $error("pad bytes set on a flit that is not the last one");

    quiet_after_reset: assert property (@(posedge clk)
        $past(rst) |-> !out_val && !drop)
        else $error("output strobe active during reset or right after it");

    meta_steady: assert property (@(posedge clk) disable iff (rst)
        out_val && !out_flit.last |=> out_val && $stable(out_meta))
        else $error("metadata changed inside one packet");

endmodule

// File: bench/udp_rx_noc_tb.sv
module udp_rx_noc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        udp_rx_pkg::rx_meta meta;
        udp_rx_pkg::rx_flit flit;
    } exp_item;

    typedef logic [udp_rx_pkg::noc_data_w-1:0] payload_t [udp_rx_pkg::lane_buf_depth];

    logic                              clk = 1'b0;
    logic                              rst;
    logic                              in_val;
    logic [udp_rx_pkg::noc_data_w-1:0] in_data;
    logic                              out_val;
    udp_rx_pkg::rx_flit                out_flit;
    udp_rx_pkg::rx_meta                out_meta;
    logic                              drop;

    exp_item     exp_q [$];
    logic [15:0] lfsr_state = 16'd2;
    string       cur_test = "reset";
    int          errors = 0;
    int          delivered = 0;
    int          drop_count = 0;
    int          tests_run = 0;
    int          tests_bad = 0;

    udp_rx_noc_top udp_rx_noc_top_i (
        .clk      (clk),
        .rst      (rst),
        .in_val   (in_val),
        .in_data  (in_data),
        .out_val  (out_val),
        .out_flit (out_flit),
        .out_meta (out_meta),
        .drop     (drop)
    );

    bind udp_rx_noc_top udp_rx_noc_checker checker_i (
        .clk (clk), .rst (rst), .out_val (out_val), .out_flit (out_flit),
        .out_meta (out_meta), .drop (drop)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] next_bits(input int n);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[126:0], lfsr_step()};
        return r;
    endfunction

    // expected output of one accepted packet, straight from the flit format rules
    function automatic void build_expected(input udp_rx_pkg::noc_hdr_flit hdr,
                                           input udp_rx_pkg::ip_meta_flit ipm,
                                           input payload_t pay);
        exp_item item;
        int      len;
        int      nflits;
        int      rem;
        len               = int'(ipm.data_payload_len);
        nflits            = (len + 15) / 16;
        rem               = len % 16;
        item.meta.src_ip    = ipm.src_ip;
        item.meta.dst_ip    = ipm.dst_ip;
        item.meta.udp_len   = ipm.data_payload_len;
        item.meta.packet_id = hdr.packet_id;
        item.meta.timestamp = hdr.timestamp;
        for (int i = 0; i < nflits; i++) begin
            item.flit.data     = pay[i];
            item.flit.last     = (i == nflits - 1);
            item.flit.padbytes = '0;
            if (item.flit.last && rem != 0) item.flit.padbytes = udp_rx_pkg::padbytes_w'(16 - rem);
            exp_q.push_back(item);
        end
    endfunction

    // drives one packet flit by flit, in_val stays high after the last flit
    task automatic send_packet(input int pay_len, input logic [15:0] pkt_id, output bit dropped);
        udp_rx_pkg::noc_hdr_flit hdr;
        udp_rx_pkg::ip_meta_flit ipm;
        payload_t                pay;
        logic [127:0]            r;
        int                      nflits;
        nflits        = (pay_len + 15) / 16;
        hdr           = '0;
        ipm           = '0;
        hdr.msg_len   = udp_rx_pkg::msg_len_w'(nflits + 2);
        hdr.packet_id = pkt_id;
        r             = next_bits(32);
        hdr.timestamp = r[31:0];
        r             = next_bits(32);
        ipm.src_ip    = r[31:0];
        r             = next_bits(32);
        ipm.dst_ip    = r[31:0];
        ipm.data_payload_len = 16'(pay_len);
        for (int i = 0; i < udp_rx_pkg::lane_buf_depth; i++) begin
            pay[i] = (i < nflits) ? next_bits(128) : '0;
        end
        @(posedge clk);
        #1;
        in_val  = 1'b1;
        in_data = hdr;
        @(posedge clk);
        #1;
        dropped = drop;     // drop is registered one cycle behind its header
        in_data = ipm;
        for (int i = 0; i < nflits; i++) begin
            @(posedge clk);
            #1;
            in_data = pay[i];
        end
        if (!dropped) build_expected(hdr, ipm, pay);
    endtask

    task automatic idle_input();
        @(posedge clk);
        #1;
        in_val  = 1'b0;
        in_data = '0;
    endtask

    task automatic wait_output_empty(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: timed out with %0d expected flits never delivered", cur_test,
                     exp_q.size());
        end
        repeat (8) @(posedge clk);   // margin so stray flits show up in this test
    endtask

    task automatic report_test(input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_bad++;
            $display("%s: FAILED with %0d errors", cur_test, errors - err_before);
        end
    endtask

    task automatic run_single(input string name, input int pay_len, input logic [15:0] id);
        bit dropped;
        int err_before;
        cur_test   = name;
        err_before = errors;
        send_packet(pay_len, id, dropped);
        idle_input();
        if (dropped) begin
            errors++;
            $display("%s: packet dropped although every lane was free", cur_test);
        end
        wait_output_empty(200);
        report_test(err_before);
    endtask

    always @(negedge clk) begin : compare
        exp_item e;
        if (drop === 1'b1) drop_count++;
        if (rst === 1'b0 && out_val === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: output flit of packet %h arrived but none was expected",
                         cur_test, out_meta.packet_id);
            end else begin
                e = exp_q.pop_front();
                if (out_flit.data !== e.flit.data) begin
                    errors++;
                    $display("ERROR %s data expected %h actual %h", cur_test, e.flit.data,
                             out_flit.data);
                end
                if (out_flit.last !== e.flit.last) begin
                    errors++;
                    $display("ERROR %s last expected %b actual %b", cur_test, e.flit.last,
                             out_flit.last);
                end
                if (out_flit.padbytes !== e.flit.padbytes) begin
                    errors++;
                    $display("ERROR %s padbytes expected %0d actual %0d", cur_test,
                             e.flit.padbytes, out_flit.padbytes);
                end
                if (out_meta !== e.meta) begin
                    errors++;
                    $display("ERROR %s meta expected %h actual %h", cur_test, e.meta, out_meta);
                end
                if (out_flit.last === 1'b1) delivered++;
            end
        end
    end

    initial begin
        bit          dropped;
        int          err_before;
        int          drops_before;
        int          deliv_before;
        int          dropped_seen;
        logic [127:0] r;
        rst     = 1'b1;
        in_val  = 1'b0;
        in_data = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);

        run_single("single_48b", 48, 16'h0001);
        run_single("single_37b", 37, 16'h0002);
        run_single("minimal_5b", 5, 16'h0003);

        cur_test     = "random_sequential";
        err_before   = errors;
        drops_before = drop_count;
        for (int i = 0; i < 20; i++) begin
            r = next_bits(7);
            send_packet(int'(r[6:0]) + 1, 16'(16'h0100 + i), dropped);
            idle_input();
            if (dropped) begin
                errors++;
                $display("%s: packet %0d dropped although the output was idle", cur_test, i);
            end
            wait_output_empty(300);
        end
        if (drop_count != drops_before) begin
            errors++;
            $display("ERROR %s drop pulses expected 0 actual %0d", cur_test,
                     drop_count - drops_before);
        end
        report_test(err_before);

        // packets back to back, a lane still busy loses its next packet
        cur_test     = "burst";
        err_before   = errors;
        drops_before = drop_count;
        deliv_before = delivered;
        dropped_seen = 0;
        for (int i = 0; i < 12; i++) begin
            r = next_bits(7);
            send_packet(int'(r[6:0]) + 1, 16'(16'h0200 + i), dropped);
            if (dropped) dropped_seen++;
        end
        idle_input();
        wait_output_empty(2000);
        if ((delivered - deliv_before) + (drop_count - drops_before) != 12) begin
            errors++;
            $display("ERROR %s delivered plus dropped expected 12 actual %0d", cur_test,
                     (delivered - deliv_before) + (drop_count - drops_before));
        end
        if (drop_count - drops_before != dropped_seen) begin
            errors++;
            $display("ERROR %s drop pulses expected %0d actual %0d", cur_test, dropped_seen,
                     drop_count - drops_before);
        end
        report_test(err_before);

        $display("tests run %0d, passing %0d, failing %0d, errors %0d", tests_run,
                 tests_run - tests_bad, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f udp_rx_noc.f --top-module udp_rx_noc_tb -o udp_rx_noc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/udp_rx_noc_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" "$log"; then
    exit 0
fi
exit 1

// File: source/udp_rx_dispatch.sv
module udp_rx_dispatch (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_val,
    input  logic [udp_rx_pkg::noc_data_w-1:0]     in_data,
    input  logic [udp_rx_pkg::num_lanes-1:0]      lane_busy,
    output logic [udp_rx_pkg::num_lanes-1:0]      lane_flit_val,
    output logic [udp_rx_pkg::noc_data_w-1:0]     lane_flit,
    output logic                                  drop
);

    udp_rx_pkg::noc_hdr_flit                      hdr_in;
    logic [udp_rx_pkg::msg_len_w-1:0]             flits_left;
    logic [udp_rx_pkg::lane_idx_w-1:0]            turn;
    logic [udp_rx_pkg::lane_idx_w-1:0]            cur_lane;
    logic                                         accept;
    logic                                         is_hdr;
    logic                                         take_hdr;
    logic [udp_rx_pkg::num_lanes-1:0]             val_next;

    assign hdr_in   = in_data;
    assign is_hdr   = in_val && (flits_left == '0);
    assign take_hdr = is_hdr && !lane_busy[turn];

    always_comb begin
        val_next = '0;
        if (take_hdr) begin
            val_next[turn] = 1'b1;
        end else if (in_val && !is_hdr && accept) begin
            val_next[cur_lane] = 1'b1;   // rest of an accepted packet follows its header
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flits_left    <= '0;
            turn          <= '0;
            cur_lane      <= '0;
            accept        <= 1'b0;
            lane_flit_val <= '0;
            drop          <= 1'b0;
        end else begin
            lane_flit_val <= val_next;
            drop          <= is_hdr && !take_hdr;
            if (is_hdr) begin
                flits_left <= hdr_in.msg_len - 1'b1;
                accept     <= take_hdr;
                if (take_hdr) begin
                    cur_lane <= turn;
                    turn     <= turn + 1'b1;
                end
            end else if (in_val) begin
                flits_left <= flits_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        lane_flit <= in_data;
    end

endmodule

// File: source/udp_rx_drain.sv
module udp_rx_drain (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [udp_rx_pkg::num_lanes-1:0]              lane_ready,
    input  udp_rx_pkg::rx_meta [udp_rx_pkg::num_lanes-1:0] lane_meta,
    input  udp_rx_pkg::rx_flit [udp_rx_pkg::num_lanes-1:0] lane_head,
    output logic [udp_rx_pkg::num_lanes-1:0]              lane_pop,
    output logic                                          out_val,
    output udp_rx_pkg::rx_flit                            out_flit,
    output udp_rx_pkg::rx_meta                            out_meta
);

    logic [udp_rx_pkg::lane_idx_w-1:0]                    turn;
    logic                                                 cur_ready;
    udp_rx_pkg::rx_flit                                   cur_head;
    udp_rx_pkg::rx_meta                                   cur_meta;

    // same lane order as the dispatcher, so packets leave in arrival order
    assign cur_ready = lane_ready[turn];
    assign cur_head  = lane_head[turn];
    assign cur_meta  = lane_meta[turn];

    always_comb begin
        lane_pop       = '0;
        lane_pop[turn] = cur_ready;     // ready stays up until the last flit is popped
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            turn    <= '0;
            out_val <= 1'b0;
        end else begin
            out_val <= cur_ready;
            if (cur_ready && cur_head.last) begin
                turn <= turn + 1'b1;
            end
        end
    end

    // held between packets so out_meta stays steady for a whole packet
    always_ff @(posedge clk) begin
        if (cur_ready) begin
            out_flit <= cur_head;
            out_meta <= cur_meta;
        end
    end

endmodule

// File: source/udp_rx_lane.sv
module udp_rx_lane (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               flit_val,
    input  logic [udp_rx_pkg::noc_data_w-1:0]  flit,
    input  logic                               pop,
    output logic                               busy,
    output logic                               ready,
    output udp_rx_pkg::rx_meta                 meta,
    output udp_rx_pkg::rx_flit                 head
);

    logic                                      store_hdr_flit;
    logic                                      store_meta_flit;
    logic                                      init_num_flits;
    logic                                      decr_num_flits;
    logic                                      buf_write;
    logic                                      last_flit;
    logic [udp_rx_pkg::padbytes_w-1:0]         padbytes;
    logic                                      drained;
    udp_rx_pkg::rx_flit                        wr_entry;
    udp_rx_pkg::rx_flit                        flit_buf [udp_rx_pkg::lane_buf_depth];
    logic [udp_rx_pkg::buf_ptr_w-1:0]          wr_ptr;
    logic [udp_rx_pkg::buf_ptr_w-1:0]          rd_ptr;

    udp_rx_noc_in_ctrl ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .flit_val        (flit_val),
        .last_flit       (last_flit),
        .drained         (drained),
        .store_hdr_flit  (store_hdr_flit),
        .store_meta_flit (store_meta_flit),
        .init_num_flits  (init_num_flits),
        .decr_num_flits  (decr_num_flits),
        .buf_write       (buf_write),
        .busy            (busy)
    );

    udp_rx_noc_in_datap datap_i (
        .clk             (clk),
        .rst             (rst),
        .in_data         (flit),
        .store_hdr_flit  (store_hdr_flit),
        .store_meta_flit (store_meta_flit),
        .init_num_flits  (init_num_flits),
        .decr_num_flits  (decr_num_flits),
        .meta            (meta),
        .last_flit       (last_flit),
        .padbytes        (padbytes)
    );

    assign wr_entry = '{data: flit, last: last_flit, padbytes: padbytes};

    always_ff @(posedge clk) begin
        if (buf_write) flit_buf[wr_ptr] <= wr_entry;
    end

    assign head    = flit_buf[rd_ptr];
    assign drained = pop && head.last;   // final flit of the packet leaves the lane

    // one packet never holds more than lane_buf_depth flits, so the pointers just wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ready  <= 1'b0;
        end else begin
            if (buf_write) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (buf_write && last_flit) begin
                ready <= 1'b1;
            end else if (drained) begin
                ready <= 1'b0;
            end
        end
    end

endmodule

// File: source/udp_rx_noc_in_ctrl.sv
module udp_rx_noc_in_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic flit_val,
    input  logic last_flit,
    input  logic drained,
    output logic store_hdr_flit,
    output logic store_meta_flit,
    output logic init_num_flits,
    output logic decr_num_flits,
    output logic buf_write,
    output logic busy
);

    udp_rx_pkg::rx_state state;
    udp_rx_pkg::rx_state state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_rx_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next      = state;
        store_hdr_flit  = 1'b0;
        store_meta_flit = 1'b0;
        init_num_flits  = 1'b0;
        decr_num_flits  = 1'b0;
        buf_write       = 1'b0;

        case (state)
            udp_rx_pkg::idle: begin
                if (flit_val) begin
                    store_hdr_flit = 1'b1;
                    init_num_flits = 1'b1;
                    state_next     = udp_rx_pkg::hdr_done;
                end
            end
            udp_rx_pkg::hdr_done: begin
                if (flit_val) begin
                    store_meta_flit = 1'b1;
                    state_next      = udp_rx_pkg::payload;
                end
            end
            udp_rx_pkg::payload: begin
                if (flit_val) begin
                    buf_write      = 1'b1;
                    decr_num_flits = 1'b1;
                    if (last_flit) begin
                        state_next = udp_rx_pkg::wait_drain;
                    end
                end
            end
            udp_rx_pkg::wait_drain: begin
                if (drained) state_next = udp_rx_pkg::idle;   // lane free for the next turn
            end
            default: state_next = udp_rx_pkg::idle;
        endcase
    end

    assign busy = state != udp_rx_pkg::idle;

endmodule

// File: source/udp_rx_noc_in_datap.sv
module udp_rx_noc_in_datap (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [udp_rx_pkg::noc_data_w-1:0]     in_data,
    input  logic                                  store_hdr_flit,
    input  logic                                  store_meta_flit,
    input  logic                                  init_num_flits,
    input  logic                                  decr_num_flits,
    output udp_rx_pkg::rx_meta                    meta,
    output logic                                  last_flit,
    output logic [udp_rx_pkg::padbytes_w-1:0]     padbytes
);

    udp_rx_pkg::noc_hdr_flit                      hdr_in;
    udp_rx_pkg::noc_hdr_flit                      hdr_reg;
    udp_rx_pkg::ip_meta_flit                      meta_reg;
    logic [udp_rx_pkg::msg_len_w-1:0]             flits_left;
    logic [udp_rx_pkg::msg_len_w-1:0]             flits_left_next;
    logic [udp_rx_pkg::padbytes_w-1:0]            len_rem;
    logic [udp_rx_pkg::padbytes_w:0]              pad_calc;

    assign hdr_in = in_data;

    always_ff @(posedge clk) begin
        if (store_hdr_flit) begin
            hdr_reg <= in_data;
        end
        if (store_meta_flit) begin
            meta_reg <= in_data;
        end
    end

    // payload flits still to come, header and metadata flits are not counted
    always_comb begin
        if (init_num_flits) begin
            flits_left_next = hdr_in.msg_len - udp_rx_pkg::msg_len_w'(2);
        end else if (decr_num_flits) begin
            flits_left_next = flits_left - 1'b1;
        end else begin
            flits_left_next = flits_left;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flits_left <= '0;
        end else begin
            flits_left <= flits_left_next;
        end
    end

    assign last_flit = flits_left == udp_rx_pkg::msg_len_w'(1);

    assign len_rem = meta_reg.data_payload_len[udp_rx_pkg::padbytes_w-1:0];

    always_comb begin
        if (len_rem == '0) begin
            pad_calc = '0;      // payload fills the last flit exactly
        end else begin
            pad_calc = (udp_rx_pkg::padbytes_w + 1)'(udp_rx_pkg::noc_data_bytes)
                       - {1'b0, len_rem};
        end
    end

    assign padbytes = last_flit ? pad_calc[udp_rx_pkg::padbytes_w-1:0] : '0;

    always_comb begin
        meta.src_ip    = meta_reg.src_ip;
        meta.dst_ip    = meta_reg.dst_ip;
        meta.udp_len   = meta_reg.data_payload_len;
        meta.packet_id = hdr_reg.packet_id;
        meta.timestamp = hdr_reg.timestamp;
    end

endmodule

// File: source/udp_rx_noc_top.sv
module udp_rx_noc_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_val,
    input  logic [udp_rx_pkg::noc_data_w-1:0]  in_data,
    output logic                               out_val,
    output udp_rx_pkg::rx_flit                 out_flit,
    output udp_rx_pkg::rx_meta                 out_meta,
    output logic                               drop
);

    logic [udp_rx_pkg::num_lanes-1:0]             lane_busy;
    logic [udp_rx_pkg::num_lanes-1:0]             lane_flit_val;
    logic [udp_rx_pkg::noc_data_w-1:0]            lane_flit;
    logic [udp_rx_pkg::num_lanes-1:0]             lane_ready;
    logic [udp_rx_pkg::num_lanes-1:0]             lane_pop;
    udp_rx_pkg::rx_meta [udp_rx_pkg::num_lanes-1:0] lane_meta;
    udp_rx_pkg::rx_flit [udp_rx_pkg::num_lanes-1:0] lane_head;

    udp_rx_dispatch dispatch_i (
        .clk           (clk),
        .rst           (rst),
        .in_val        (in_val),
        .in_data       (in_data),
        .lane_busy     (lane_busy),
        .lane_flit_val (lane_flit_val),
        .lane_flit     (lane_flit),
        .drop          (drop)
    );

    for (genvar i = 0; i < udp_rx_pkg::num_lanes; i++) begin : g_lane
        udp_rx_lane lane_i (
            .clk      (clk),
            .rst      (rst),
            .flit_val (lane_flit_val[i]),
            .flit     (lane_flit),
            .pop      (lane_pop[i]),
            .busy     (lane_busy[i]),
            .ready    (lane_ready[i]),
            .meta     (lane_meta[i]),
            .head     (lane_head[i])
        );
    end

    udp_rx_drain drain_i (
        .clk        (clk),
        .rst        (rst),
        .lane_ready (lane_ready),
        .lane_meta  (lane_meta),
        .lane_head  (lane_head),
        .lane_pop   (lane_pop),
        .out_val    (out_val),
        .out_flit   (out_flit),
        .out_meta   (out_meta)
    );

endmodule

// File: source/udp_rx_pkg.sv
package udp_rx_pkg;

    localparam int noc_data_w     = 128;
    localparam int noc_data_bytes = 16;
    localparam int padbytes_w     = 4;    // enough to count the bytes of one flit
    localparam int num_lanes      = 4;
    localparam int lane_idx_w     = 2;
    localparam int lane_buf_depth = 8;    // so msg_len is at most 10 flits
    localparam int buf_ptr_w      = $clog2(lane_buf_depth);
    localparam int msg_len_w      = 8;

    // flit 0 of every packet, msg_len counts the header and metadata flits too
    typedef struct packed {
        logic [msg_len_w-1:0] msg_len;
        logic [15:0]          packet_id;
        logic [31:0]          timestamp;
        logic [71:0]          reserved;
    } noc_hdr_flit;

    // flit 1, filled in by the IP stage upstream
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] data_payload_len;
        logic [47:0] reserved;
    } ip_meta_flit;

    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] udp_len;
        logic [15:0] packet_id;
        logic [31:0] timestamp;
    } rx_meta;

    typedef struct packed {
        logic [noc_data_w-1:0] data;
        logic                  last;
        logic [padbytes_w-1:0] padbytes;
    } rx_flit;

    typedef enum logic [1:0] {
        idle,
        hdr_done,
        payload,
        wait_drain      // whole packet buffered, waiting for the drain to empty it
    } rx_state;

endpackage

// File: udp_rx_noc.f
source/udp_rx_pkg.sv
source/udp_rx_noc_in_datap.sv
source/udp_rx_noc_in_ctrl.sv
source/udp_rx_lane.sv
source/udp_rx_dispatch.sv
source/udp_rx_drain.sv
source/udp_rx_noc_top.sv
bench/udp_rx_noc_checker.sv
bench/udp_rx_noc_tb.sv
